/* hw/pmaMap_config.svh */
`ifndef PMA_MAP_CONFIG_SVH
`define PMA_MAP_CONFIG_SVH

// Physical address width
`define PA_BITS 34
// Region-select width, slot 0 is the no-match flag
`define REGION_COUNT 12

// Permission encodings
// Bit 2 read, bit 1 write, bit 0 execute
`define PERM_RX  3'b101
`define PERM_RW  3'b110
`define PERM_RWX 3'b111

// Supported-size masks, bit n allows accessSize value n
`define SIZES_ALL  4'b1111
`define SIZES_WORD 4'b0100
`define SIZES_WD   4'b1100
`define SIZES_BYTE 4'b0001

// Peripherals
`define SPI_BASE          34'h0_1004_0000
`define SPI_MASK          34'h0_0000_0fff
`define SPI_PERM          `PERM_RW
`define SPI_SIZES         `SIZES_WORD
`define UART_BASE         34'h0_1000_0000
`define UART_MASK         34'h0_0000_0007
`define UART_PERM         `PERM_RW
`define UART_SIZES        `SIZES_BYTE
`define CLINT_BASE        34'h0_0200_0000
`define CLINT_MASK        34'h0_0000_ffff
`define CLINT_PERM        `PERM_RW
`define CLINT_SIZES       `SIZES_WD
`define PLIC_BASE         34'h0_0c00_0000
`define PLIC_MASK         34'h0_03ff_ffff
`define PLIC_PERM         `PERM_RW
`define PLIC_SIZES        `SIZES_WORD
`define GPIO_BASE         34'h0_1006_0000
`define GPIO_MASK         34'h0_0000_00ff
`define GPIO_PERM         `PERM_RW
`define GPIO_SIZES        `SIZES_WORD

// Memories
`define FLASH_BASE        34'h0_2000_0000
`define FLASH_MASK        34'h0_0fff_ffff
`define FLASH_PERM        `PERM_RX
`define FLASH_SIZES       `SIZES_ALL
`define MAINRAM_BASE      34'h0_8000_0000
`define MAINRAM_MASK      34'h0_7fff_ffff
`define MAINRAM_PERM      `PERM_RWX
`define MAINRAM_SIZES     `SIZES_ALL
`define BOOTROM_BASE      34'h0_0000_1000
`define BOOTROM_MASK      34'h0_0000_0fff
`define BOOTROM_PERM      `PERM_RX
`define BOOTROM_SIZES     `SIZES_ALL
`define UNCACHEDRAM_BASE  34'h0_6000_0000
`define UNCACHEDRAM_MASK  34'h0_0fff_ffff
`define UNCACHEDRAM_PERM  `PERM_RW
`define UNCACHEDRAM_SIZES `SIZES_ALL
`define IROM_BASE         34'h0_0000_4000
`define IROM_MASK         34'h0_0000_3fff
`define IROM_PERM         `PERM_RX
`define IROM_SIZES        `SIZES_ALL
`define DTIM_BASE         34'h0_0001_0000
`define DTIM_MASK         34'h0_0000_ffff
`define DTIM_PERM         `PERM_RWX
`define DTIM_SIZES        `SIZES_ALL

`endif

/* hw/pmaPkg.sv */
`include "pmaMap_config.svh"

package pmaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Access descriptors
  ////////////////////////////////////////////////////////////////////////////

  // Access width, encoding doubles as bit index into a supported-size mask
  typedef enum logic [1:0] {
    sizeByte,
    sizeHalf,
    sizeWord,
    sizeDouble
  } accessSize;

  // Page-based memory type from the translation unit
  // Pma defers to the region, nc and io override it
  typedef enum logic [1:0] {
    memPma,
    memNc,
    memIo,
    memReserved
  } memType;

  ////////////////////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////////////////////

  // One-hot region select, bit 0 flags no match
  typedef logic [`REGION_COUNT-1:0] regionSel;

endpackage

/* hw/adrdec.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// Single region decoder
// Hits when the address falls in the region and the access is legal there
module adrdec import pmaPkg::*; #(
  parameter logic [`PA_BITS-1:0] base     = '0,
  parameter logic [`PA_BITS-1:0] sizeMask = '0
) (
  input  logic [`PA_BITS-1:0] physicalAddress,
  // Access class routed in by the region's permission
  input  logic                accessValid,
  input  accessSize           size,
  // Bit n set when accessSize value n is supported
  input  logic [3:0]          supportedSizes,
  output logic                sel
);

  logic addrMatch;
  logic sizeOk;

  // Region is a power-of-two window, base aligned to the mask
  // Masked bits are the offset inside the region
  assign addrMatch = ((physicalAddress & ~sizeMask) == base);

  // Size encoding indexes the mask directly
  assign sizeOk = supportedSizes[size];

  // All three must hold, otherwise the access drops into region 0
  assign sel = addrMatch & accessValid & sizeOk;

endmodule

/* hw/adrdecs.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// Memory-map table
// Eleven region decoders plus the no-region flag in bit 0
module adrdecs import pmaPkg::*; (
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  logic                accessRW,
  input  logic                accessRX,
  input  logic                accessRWX,
  input  accessSize           size,
  output regionSel            selRegions
);

  ////////////////////////////////////////////////////////////////////////////
  // Region table, index matches the select bit
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [`PA_BITS-1:0] regionBase [1:`REGION_COUNT-1] = '{
    `SPI_BASE, `UART_BASE, `CLINT_BASE, `PLIC_BASE, `GPIO_BASE, `FLASH_BASE,
    `MAINRAM_BASE, `BOOTROM_BASE, `UNCACHEDRAM_BASE, `IROM_BASE, `DTIM_BASE
  };
  localparam logic [`PA_BITS-1:0] regionMask [1:`REGION_COUNT-1] = '{
    `SPI_MASK, `UART_MASK, `CLINT_MASK, `PLIC_MASK, `GPIO_MASK, `FLASH_MASK,
    `MAINRAM_MASK, `BOOTROM_MASK, `UNCACHEDRAM_MASK, `IROM_MASK, `DTIM_MASK
  };
  localparam logic [2:0] regionPerm [1:`REGION_COUNT-1] = '{
    `SPI_PERM, `UART_PERM, `CLINT_PERM, `PLIC_PERM, `GPIO_PERM, `FLASH_PERM,
    `MAINRAM_PERM, `BOOTROM_PERM, `UNCACHEDRAM_PERM, `IROM_PERM, `DTIM_PERM
  };
  localparam logic [3:0] regionSizes [1:`REGION_COUNT-1] = '{
    `SPI_SIZES, `UART_SIZES, `CLINT_SIZES, `PLIC_SIZES, `GPIO_SIZES, `FLASH_SIZES,
    `MAINRAM_SIZES, `BOOTROM_SIZES, `UNCACHEDRAM_SIZES, `IROM_SIZES, `DTIM_SIZES
  };

  logic [`REGION_COUNT-1:1] classSel;

  // Route the access class that matches a permission code
  function automatic logic pickClass(
    input logic [2:0] perm,
    input logic       rw,
    input logic       rx,
    input logic       rwx
  );
    case (perm)
      `PERM_RWX: pickClass = rwx;
      `PERM_RX:  pickClass = rx;
      `PERM_RW:  pickClass = rw;
      default:   pickClass = 1'b0;
    endcase
  endfunction

  for (genvar i = 1; i < `REGION_COUNT; i++) begin : gRegion
    assign classSel[i] = pickClass(regionPerm[i], accessRW, accessRX, accessRWX);
    adrdec #(.base(regionBase[i]), .sizeMask(regionMask[i])) dec (
      .physicalAddress(physicalAddress),
      .accessValid(classSel[i]),
      .size(size),
      .supportedSizes(regionSizes[i]),
      .sel(selRegions[i])
    );
  end

  // Bases never overlap, so at most one region bit is set
  // Nothing hit means the access is illegal
  assign selRegions[0] = ~|selRegions[`REGION_COUNT-1:1];

endmodule

/* hw/pmachecker.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// Physical memory attribute checker
// Finds the region an access hits, reports its attributes and access faults
module pmachecker import pmaPkg::*; (
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  accessSize           size,
  input  logic                atomicAccess,
  input  logic                executeAccess,
  input  logic                writeAccess,
  input  logic                readAccess,
  // Memory type from the page table entry
  input  memType              pbMemoryType,
  output logic                cacheable,
  output logic                idempotent,
  output logic                selTim,
  output logic                instrAccessFault,
  output logic                loadAccessFault,
  output logic                storeAmoAccessFault
);

  logic     accessRW;
  logic     accessRX;
  logic     accessRWX;
  regionSel selRegions;
  logic     cacheableRegion;
  logic     idempotentRegion;
  logic     atomicAllowed;
  logic     accessFault;

  ////////////////////////////////////////////////////////////////////////////
  // Access class and region decode
  ////////////////////////////////////////////////////////////////////////////

  // Each region is gated by one of these classes
  assign accessRW  = readAccess | writeAccess;
  assign accessRX  = readAccess | executeAccess;
  assign accessRWX = readAccess | writeAccess | executeAccess;

  adrdecs adrdecsInst (
    .physicalAddress(physicalAddress),
    .accessRW(accessRW),
    .accessRX(accessRX),
    .accessRWX(accessRWX),
    .size(size),
    .selRegions(selRegions)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Attributes
  ////////////////////////////////////////////////////////////////////////////

  // Flash, main RAM and boot ROM sit behind the caches
  assign cacheableRegion = selRegions[8] | selRegions[7] | selRegions[6];
  // Any page type other than pma makes the access uncached
  assign cacheable = (pbMemoryType == memPma) & cacheableRegion;

  // Memories can be re-read without side effects, peripherals cannot
  assign idempotentRegion = selRegions[11] | selRegions[9] | selRegions[8]
                          | selRegions[7] | selRegions[6];
  // Nc forces idempotent, io and reserved force non-idempotent
  assign idempotent = (pbMemoryType == memPma) ? idempotentRegion
                                               : (pbMemoryType == memNc);

  // AMOs only on writable RAM
  assign atomicAllowed = selRegions[11] | selRegions[9] | selRegions[7];

  // Irom and dtim are the tightly integrated memories
  assign selTim = selRegions[11] | selRegions[10];

  ////////////////////////////////////////////////////////////////////////////
  // Faults
  ////////////////////////////////////////////////////////////////////////////

  // No region, or an AMO where the region cannot do one
  assign accessFault = (selRegions[0] & accessRWX) | (atomicAccess & ~atomicAllowed);

  // Steer the fault to the pipeline stage that made the access
  assign instrAccessFault    = executeAccess & accessFault;
  assign loadAccessFault     = readAccess & accessFault;
  assign storeAmoAccessFault = writeAccess & accessFault;

endmodule

/* hw/pmaPort.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// Four-phase req/ack port in front of the checker
// Captures one access, registers the results and holds them until release
module pmaPort import pmaPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  output logic                ack,
  // Access from the requester
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  logic [1:0]          size,
  input  logic                atomicAccess,
  input  logic                executeAccess,
  input  logic                writeAccess,
  input  logic                readAccess,
  input  logic [1:0]          pbMemoryType,
  // Captured access toward the checker
  output logic [`PA_BITS-1:0] chkPhysicalAddress,
  output accessSize           chkSize,
  output logic                chkAtomicAccess,
  output logic                chkExecuteAccess,
  output logic                chkWriteAccess,
  output logic                chkReadAccess,
  output memType              chkPbMemoryType,
  // Combinational results from the checker
  input  logic                chkCacheable,
  input  logic                chkIdempotent,
  input  logic                chkSelTim,
  input  logic                chkInstrAccessFault,
  input  logic                chkLoadAccessFault,
  input  logic                chkStoreAmoAccessFault,
  // Held results
  output logic                cacheable,
  output logic                idempotent,
  output logic                selTim,
  output logic                instrAccessFault,
  output logic                loadAccessFault,
  output logic                storeAmoAccessFault
);

  typedef enum logic [1:0] {stIdle, stCheck, stAck} portState;

  portState state;
  logic     capture;
  logic     latch;

  // New access only from idle with ack already low
  assign capture = (state == stIdle) & req & ~ack;
  // Checker output is valid one cycle after capture
  assign latch = (state == stCheck);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
      ack   <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (capture) state <= stCheck;
        end
        stCheck: begin
          state <= stAck;
          ack   <= 1'b1;
        end
        stAck: begin
          // Hold until the requester lets go
          if (!req) begin
            state <= stIdle;
            ack   <= 1'b0;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Access payload
  always_ff @(posedge clk) begin
    if (capture) begin
      chkPhysicalAddress <= physicalAddress;
      chkSize            <= accessSize'(size);
      chkAtomicAccess    <= atomicAccess;
      chkExecuteAccess   <= executeAccess;
      chkWriteAccess     <= writeAccess;
      chkReadAccess      <= readAccess;
      chkPbMemoryType    <= memType'(pbMemoryType);
    end
  end

  // Results, cleared so outputs read low before the first access
  always_ff @(posedge clk) begin
    if (reset) begin
      cacheable           <= 1'b0;
      idempotent          <= 1'b0;
      selTim              <= 1'b0;
      instrAccessFault    <= 1'b0;
      loadAccessFault     <= 1'b0;
      storeAmoAccessFault <= 1'b0;
    end else if (latch) begin
      cacheable           <= chkCacheable;
      idempotent          <= chkIdempotent;
      selTim              <= chkSelTim;
      instrAccessFault    <= chkInstrAccessFault;
      loadAccessFault     <= chkLoadAccessFault;
      storeAmoAccessFault <= chkStoreAmoAccessFault;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Ack is an answer, never unsolicited
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> req);

  // Ack may only fall after req has dropped
  ackHeld: assert property (@(posedge clk) disable iff (reset)
    ack && req |=> ack);

  // Requester may sample results any cycle ack is high
  resultsFrozen: assert property (@(posedge clk) disable iff (reset)
    ack |=> !ack || $stable({cacheable, idempotent, selTim, instrAccessFault,
                            loadAccessFault, storeAmoAccessFault}));

endmodule

/* hw/pmaSubsystem.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// PMA checking subsystem
// Request port plus combinational checker
module pmaSubsystem import pmaPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  output logic                ack,
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  logic [1:0]          size,
  input  logic                atomicAccess,
  input  logic                executeAccess,
  input  logic                writeAccess,
  input  logic                readAccess,
  input  logic [1:0]          pbMemoryType,
  output logic                cacheable,
  output logic                idempotent,
  output logic                selTim,
  output logic                instrAccessFault,
  output logic                loadAccessFault,
  output logic                storeAmoAccessFault
);

  // Captured access
  logic [`PA_BITS-1:0] chkPhysicalAddress;
  accessSize           chkSize;
  logic                chkAtomicAccess;
  logic                chkExecuteAccess;
  logic                chkWriteAccess;
  logic                chkReadAccess;
  memType              chkPbMemoryType;
  // Unregistered results
  logic                chkCacheable;
  logic                chkIdempotent;
  logic                chkSelTim;
  logic                chkInstrAccessFault;
  logic                chkLoadAccessFault;
  logic                chkStoreAmoAccessFault;

  pmaPort pmaPortInst (
    .clk(clk),
    .reset(reset),
    .req(req),
    .ack(ack),
    .physicalAddress(physicalAddress),
    .size(size),
    .atomicAccess(atomicAccess),
    .executeAccess(executeAccess),
    .writeAccess(writeAccess),
    .readAccess(readAccess),
    .pbMemoryType(pbMemoryType),
    .chkPhysicalAddress(chkPhysicalAddress),
    .chkSize(chkSize),
    .chkAtomicAccess(chkAtomicAccess),
    .chkExecuteAccess(chkExecuteAccess),
    .chkWriteAccess(chkWriteAccess),
    .chkReadAccess(chkReadAccess),
    .chkPbMemoryType(chkPbMemoryType),
    .chkCacheable(chkCacheable),
    .chkIdempotent(chkIdempotent),
    .chkSelTim(chkSelTim),
    .chkInstrAccessFault(chkInstrAccessFault),
    .chkLoadAccessFault(chkLoadAccessFault),
    .chkStoreAmoAccessFault(chkStoreAmoAccessFault),
    .cacheable(cacheable),
    .idempotent(idempotent),
    .selTim(selTim),
    .instrAccessFault(instrAccessFault),
    .loadAccessFault(loadAccessFault),
    .storeAmoAccessFault(storeAmoAccessFault)
  );

  pmachecker pmacheckerInst (
    .physicalAddress(chkPhysicalAddress),
    .size(chkSize),
    .atomicAccess(chkAtomicAccess),
    .executeAccess(chkExecuteAccess),
    .writeAccess(chkWriteAccess),
    .readAccess(chkReadAccess),
    .pbMemoryType(chkPbMemoryType),
    .cacheable(chkCacheable),
    .idempotent(chkIdempotent),
    .selTim(chkSelTim),
    .instrAccessFault(chkInstrAccessFault),
    .loadAccessFault(chkLoadAccessFault),
    .storeAmoAccessFault(chkStoreAmoAccessFault)
  );

endmodule

/* test/pmaSubsystemTb.sv */
`timescale 1ns/1ns
`include "pmaMap_config.svh"

// Trace-driven testbench for the PMA subsystem
// Each trace line is one four-phase access plus its expected results
module pmaSubsystemTb;

  // Reset length in clock cycles
  localparam int ResetCycles = 4;
  // Cycle budget for one trace line
  localparam int CyclesPerAccess = 16;

  logic                clk = 1'b0;
  logic                reset;
  logic                req;
  logic                ack;
  logic [`PA_BITS-1:0] physicalAddress;
  logic [1:0]          size;
  logic                atomicAccess;
  logic                executeAccess;
  logic                writeAccess;
  logic                readAccess;
  logic [1:0]          pbMemoryType;
  logic                cacheable;
  logic                idempotent;
  logic                selTim;
  logic                instrAccessFault;
  logic                loadAccessFault;
  logic                storeAmoAccessFault;

  // Trace contents
  logic [`PA_BITS-1:0] addrQ [$];
  logic [1:0]          sizeQ [$];
  // Atomic, execute, write, read
  logic [3:0]          flagsQ [$];
  logic [1:0]          typeQ [$];
  // Cacheable, idempotent, selTim, instr, load, store/AMO fault
  logic [5:0]          expectQ [$];

  logic [31:0] lfsrState = 32'ha552;
  int          cycleCount = 0;
  int          cycleLimit = 1000;

  pmaSubsystem pmaSubsystem_inst (
    .clk(clk),
    .reset(reset),
    .req(req),
    .ack(ack),
    .physicalAddress(physicalAddress),
    .size(size),
    .atomicAccess(atomicAccess),
    .executeAccess(executeAccess),
    .writeAccess(writeAccess),
    .readAccess(readAccess),
    .pbMemoryType(pbMemoryType),
    .cacheable(cacheable),
    .idempotent(idempotent),
    .selTim(selTim),
    .instrAccessFault(instrAccessFault),
    .loadAccessFault(loadAccessFault),
    .storeAmoAccessFault(storeAmoAccessFault)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic compareValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      failRun("DUT output does not match the trace");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int count, output int value);
    value = 0;
    for (int b = 0; b < count; b++) begin
      lfsrState = nextLfsr(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic checkResults(input logic [5:0] expected);
    compareValue("cacheable", 64'(cacheable), 64'(expected[5]));
    compareValue("idempotent", 64'(idempotent), 64'(expected[4]));
    compareValue("selTim", 64'(selTim), 64'(expected[3]));
    compareValue("instrAccessFault", 64'(instrAccessFault), 64'(expected[2]));
    compareValue("loadAccessFault", 64'(loadAccessFault), 64'(expected[1]));
    compareValue("storeAmoAccessFault", 64'(storeAmoAccessFault), 64'(expected[0]));
  endtask

  // Lines starting with # are comments
  // Data lines hold 13 hex fields
  task automatic loadTrace();
    int                  fd;
    int                  status;
    int                  fields;
    string               lineText;
    logic [`PA_BITS-1:0] addrVal;
    logic [1:0]          sizeVal;
    logic [1:0]          typeVal;
    logic                atomVal;
    logic                execVal;
    logic                writeVal;
    logic                readVal;
    logic                cacheVal;
    logic                idemVal;
    logic                timVal;
    logic                instrVal;
    logic                loadVal;
    logic                storeVal;
    fd = $fopen("test/pmaTrace.txt", "r");
    if (fd == 0) failRun("Cannot open the trace file test/pmaTrace.txt");
    while (!$feof(fd)) begin
      lineText = "";
      status = $fgets(lineText, fd);
      if (status > 0 && lineText.len() > 0 && lineText[0] != "#") begin
        fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         addrVal, sizeVal, atomVal, execVal, writeVal, readVal, typeVal,
                         cacheVal, idemVal, timVal, instrVal, loadVal, storeVal);
        if (fields == 13) begin
          addrQ.push_back(addrVal);
          sizeQ.push_back(sizeVal);
          flagsQ.push_back({atomVal, execVal, writeVal, readVal});
          typeQ.push_back(typeVal);
          expectQ.push_back({cacheVal, idemVal, timVal, instrVal, loadVal, storeVal});
        end else if (fields > 0) begin
          failRun("Trace file has a line with missing fields");
        end
      end
    end
    $fclose(fd);
    if (addrQ.size() == 0) failRun("Trace file holds no accesses");
  endtask

  // Full four-phase access with random idle gap and hold time
  task automatic runAccess(input int idx);
    int gap;
    int hold;
    int edges;
    drawBits(3, gap);
    repeat (gap) @(posedge clk);
    @(posedge clk);
    physicalAddress <= addrQ[idx];
    size            <= sizeQ[idx];
    {atomicAccess, executeAccess, writeAccess, readAccess} <= flagsQ[idx];
    pbMemoryType    <= typeQ[idx];
    req             <= 1'b1;

    // Ack must appear on the second edge after req is seen
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack);
    compareValue("ack rise latency", 64'(edges), 64'd2);
    checkResults(expectQ[idx]);

    // Back-pressure keeps ack high and the results frozen
    drawBits(3, hold);
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      compareValue("ack", 64'(ack), 64'd1);
      checkResults(expectQ[idx]);
    end

    @(posedge clk);
    req <= 1'b0;
    // Ack drops on the first edge that sees req low
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack);
    compareValue("ack fall latency", 64'(edges), 64'd1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset               <= 1'b1;
    req                 <= 1'b0;
    physicalAddress     <= '0;
    size                <= 2'b00;
    atomicAccess        <= 1'b0;
    executeAccess       <= 1'b0;
    writeAccess         <= 1'b0;
    readAccess          <= 1'b0;
    pbMemoryType        <= 2'b00;
    loadTrace();
    cycleLimit = addrQ.size() * CyclesPerAccess + ResetCycles;

    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;

    // Everything low out of reset
    @(negedge clk);
    compareValue("ack", 64'(ack), 64'd0);
    checkResults(6'b000000);

    for (int idx = 0; idx < addrQ.size(); idx++) begin
      runAccess(idx);
    end

    $display("all tests passed");
    $finish;
  end

  // Watchdog on a stalled handshake
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      failRun("Timeout, the handshake did not finish within the cycle limit");
    end
  end

endmodule

/* test/pmaTrace.txt */
# addr size atomic execute write read memType (0 pma 1 nc 2 io 3 reserved)
# then expected cacheable idempotent selTim instrFault loadFault storeAmoFault
080001000 2 0 0 0 1 0 1 1 0 0 0 0
0FFFFFFF8 3 0 0 1 0 0 1 1 0 0 0 0
080000000 2 0 1 0 0 0 1 1 0 0 0 0
000001000 2 0 1 0 0 0 1 1 0 0 0 0
000001FFF 0 0 0 0 1 0 1 1 0 0 0 0
020000100 1 0 1 0 0 0 1 1 0 0 0 0
02FFFFFF8 3 0 0 0 1 0 1 1 0 0 0 0
000010000 2 0 0 0 1 0 0 1 1 0 0 0
00001FFFC 2 0 0 1 0 0 0 1 1 0 0 0
000018000 2 0 1 0 0 0 0 1 1 0 0 0
000004000 2 0 1 0 0 0 0 0 1 0 0 0
000007FFC 2 0 0 0 1 0 0 0 1 0 0 0
060000010 2 0 0 1 0 0 0 1 0 0 0 0
010000003 0 0 0 0 1 0 0 0 0 0 0 0
010000007 0 0 0 1 0 0 0 0 0 0 0 0
010040FFC 2 0 0 0 1 0 0 0 0 0 0 0
00200BFF8 3 0 0 1 0 0 0 0 0 0 0 0
00C000004 2 0 0 0 1 0 0 0 0 0 0 0
010060010 2 0 0 1 0 0 0 0 0 0 0 0
080000040 2 0 0 0 1 1 0 1 0 0 0 0
080000040 2 0 0 0 1 2 0 0 0 0 0 0
010000000 0 0 0 0 1 1 0 1 0 0 0 0
000010040 2 0 0 1 0 2 0 0 1 0 0 0
000001040 2 0 1 0 0 3 0 0 0 0 0 0
020000000 3 0 0 0 1 1 0 1 0 0 0 0
040000000 2 0 0 0 1 0 0 0 0 0 1 0
000000000 2 0 1 0 0 0 0 0 0 1 0 0
200000000 2 0 0 1 0 0 0 0 0 0 0 1
010000000 0 0 1 0 0 0 0 0 0 1 0 0
00C000000 2 0 1 0 0 0 0 0 0 1 0 0
000001000 2 0 0 1 0 0 0 0 0 0 0 1
000004000 3 0 0 1 0 0 0 0 0 0 0 1
010000000 2 0 0 0 1 0 0 0 0 0 1 0
010040000 0 0 0 1 0 0 0 0 0 0 0 1
002000000 1 0 0 0 1 0 0 0 0 0 1 0
040000000 2 0 0 0 1 1 0 1 0 0 1 0
040000000 2 0 0 0 0 0 0 0 0 0 0 0
080000100 2 1 0 1 1 0 1 1 0 0 0 0
060000008 3 1 0 1 1 0 0 1 0 0 0 0
000010100 2 1 0 1 1 0 0 1 1 0 0 0
000001100 2 1 0 1 1 0 1 1 0 0 1 1
010000004 0 1 0 1 1 0 0 0 0 0 1 1
080000200 2 1 0 1 1 2 0 0 0 0 0 0

/* pmaSubsystem.f */
+incdir+hw
hw/pmaPkg.sv
hw/adrdec.sv
hw/adrdecs.sv
hw/pmachecker.sv
hw/pmaPort.sv
hw/pmaSubsystem.sv
test/pmaSubsystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PMA subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f pmaSubsystem.f \
  --top-module pmaSubsystemTb

# The simulator exits non-zero on a failure, keep its output for the search
simOutput="$(./obj_dir/VpmaSubsystemTb 2>&1 || true)"
echo "$simOutput"

if grep -qx "all tests passed" <<< "$simOutput"; then
  exit 0
else
  exit 1
fi
